// ==== design/pov_pkg.sv ====
package pov_pkg;

    // spi frame layout, opcode byte first
    localparam int OPCODE_BITS = 8;
    localparam int FRAME_BITS = 56;
    localparam int PAYLOAD_BITS = FRAME_BITS - OPCODE_BITS;

    // bit counter saturates one past a full frame
    localparam int FRAME_CNT_BITS = $clog2(FRAME_BITS + 2);

    // driver chain word sizes
    localparam int CONF_BITS = 48;
    localparam int LEDS_PER_COLUMN = 10;
    localparam int COLUMN_BITS = LEDS_PER_COLUMN * 3;
    localparam int ROTATION_BITS = 16;

    localparam int COUNT_BITS = 8;

    typedef enum logic [OPCODE_BITS-1:0] {
        OP_CONFIG   = 8'h01,
        OP_COLUMN   = 8'h02,
        OP_ROTATION = 8'h03
    } opcode_t;

    // function control word for the drivers
    typedef logic [CONF_BITS-1:0] conf_t;

    // one column, 10 leds x rgb
    typedef logic [COLUMN_BITS-1:0] column_t;

    typedef logic [ROTATION_BITS-1:0] rotation_t;

    // column uses the low 30 bits, rotation the low 16
    typedef logic [PAYLOAD_BITS-1:0] payload_t;

    // wraps on overflow
    typedef logic [COUNT_BITS-1:0] count_t;

endpackage

// ==== design/cmd_if.sv ====
interface cmd_if import pov_pkg::*; ();

    // four-phase handshake
    logic req;
    logic ack;

    // held stable by the issuer while req is high
    opcode_t  op;
    payload_t payload;

    modport issuer (
        output req,
        output op,
        output payload,
        input  ack
    );

    modport performer (
        input  req,
        input  op,
        input  payload,
        output ack
    );

endinterface

// ==== design/spi_frame_rx.sv ====
module spi_frame_rx import pov_pkg::*; (
    input  logic                  clock_33,
    input  logic                  nrst,
    input  logic                  spi_clk,
    input  logic                  spi_ss,
    input  logic                  spi_mosi,
    input  logic                  frame_take,
    output logic                  frame_valid,
    output logic [FRAME_BITS-1:0] frame_data,
    output logic                  overrun_pulse
);

    logic                      clk_meta, clk_sync, clk_prev;
    logic                      ss_meta, ss_sync, ss_prev;
    logic                      mosi_meta, mosi_sync;
    logic                      clk_rise;
    logic                      ss_release;
    logic                      frame_end;
    logic                      hold_full;
    logic [FRAME_CNT_BITS-1:0] bit_cnt;
    logic [FRAME_BITS-1:0]     shift_reg;

    // two-flop synchronizers, ss idles high
    always_ff @(posedge clock_33 or negedge nrst) begin
        if (!nrst) begin
            clk_meta  <= 1'b0;
            clk_sync  <= 1'b0;
            clk_prev  <= 1'b0;
            ss_meta   <= 1'b1;
            ss_sync   <= 1'b1;
            ss_prev   <= 1'b1;
            mosi_meta <= 1'b0;
            mosi_sync <= 1'b0;
        end else begin
            clk_meta  <= spi_clk;
            clk_sync  <= clk_meta;
            clk_prev  <= clk_sync;
            ss_meta   <= spi_ss;
            ss_sync   <= ss_meta;
            ss_prev   <= ss_sync;
            mosi_meta <= spi_mosi;
            mosi_sync <= mosi_meta;
        end
    end

    assign clk_rise   = clk_sync & ~clk_prev & ~ss_sync;
    assign ss_release = ss_sync & ~ss_prev;

    // pending frame that the decoder is not taking this cycle
    assign hold_full = frame_valid & ~frame_take;

    always_ff @(posedge clock_33 or negedge nrst) begin
        if (!nrst) begin
            bit_cnt       <= '0;
            frame_end     <= 1'b0;
            frame_valid   <= 1'b0;
            overrun_pulse <= 1'b0;
        end else begin
            overrun_pulse <= 1'b0;
            frame_end     <= ss_release && (bit_cnt == FRAME_CNT_BITS'(FRAME_BITS));
            if (ss_sync) begin
                bit_cnt <= '0;
            end else if (clk_rise && bit_cnt != FRAME_CNT_BITS'(FRAME_BITS + 1)) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
            // a second completed frame is dropped
            if (frame_end) begin
                if (hold_full) begin
                    overrun_pulse <= 1'b1;
                end else begin
                    frame_valid <= 1'b1;
                end
            end else if (frame_take) begin
                frame_valid <= 1'b0;
            end
        end
    end

    // msb arrives first
    always_ff @(posedge clock_33) begin
        if (clk_rise) begin
            shift_reg <= {shift_reg[FRAME_BITS-2:0], mosi_sync};
        end
        if (frame_end && !hold_full) begin
            frame_data <= shift_reg;
        end
    end

endmodule

// ==== design/command_decoder.sv ====
module command_decoder import pov_pkg::*; (
    input  logic                  clock_33,
    input  logic                  nrst,
    input  logic                  frame_valid,
    input  logic [FRAME_BITS-1:0] frame_data,
    output logic                  frame_take,
    output logic                  bad_pulse,
    output logic                  idle,
    cmd_if.issuer                 cmd
);

    typedef enum logic [1:0] {
        DEC_IDLE,
        DEC_REQ,
        DEC_RELEASE
    } dec_state_t;

    dec_state_t             state;
    logic [OPCODE_BITS-1:0] opcode_raw;
    logic                   op_known;
    logic                   accept;

    assign opcode_raw = frame_data[FRAME_BITS-1 -: OPCODE_BITS];

    always_comb begin
        case (opcode_raw)
            OP_CONFIG, OP_COLUMN, OP_ROTATION: op_known = 1'b1;
            default:                           op_known = 1'b0;
        endcase
    end

    // frame is taken as soon as the decoder is free
    assign accept     = (state == DEC_IDLE) & frame_valid;
    assign frame_take = accept;
    assign bad_pulse  = accept & ~op_known;
    assign idle       = (state == DEC_IDLE);

    always_ff @(posedge clock_33 or negedge nrst) begin
        if (!nrst) begin
            state   <= DEC_IDLE;
            cmd.req <= 1'b0;
        end else begin
            case (state)
                DEC_IDLE: begin
                    if (accept && op_known) begin
                        cmd.req <= 1'b1;
                        state   <= DEC_REQ;
                    end
                end
                DEC_REQ: begin
                    if (cmd.ack) begin
                        cmd.req <= 1'b0;
                        state   <= DEC_RELEASE;
                    end
                end
                // wait for the executor to drop ack
                DEC_RELEASE: begin
                    if (!cmd.ack) begin
                        state <= DEC_IDLE;
                    end
                end
                default: state <= DEC_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock_33) begin
        if (accept && op_known) begin
            cmd.op      <= opcode_t'(opcode_raw);
            cmd.payload <= frame_data[PAYLOAD_BITS-1:0];
        end
    end

endmodule

// ==== design/driver_shifter.sv ====
module driver_shifter #(
    parameter type word_t = logic [7:0]
) (
    input  logic  clock_33,
    input  logic  nrst,
    input  logic  start,
    input  word_t word,
    output logic  busy,
    output logic  sclk,
    output logic  sin
);

    typedef logic [$clog2($bits(word_t) + 1)-1:0] cnt_t;

    word_t shift_reg;
    cnt_t  bit_cnt;
    logic  load;

    // start during a word is ignored
    assign load = start & ~busy;
    assign busy = (bit_cnt != '0);

    // msb first, low once the word is done
    assign sin = busy & shift_reg[$bits(word_t)-1];

    // two cycles per bit, sclk high in the second
    always_ff @(posedge clock_33 or negedge nrst) begin
        if (!nrst) begin
            bit_cnt <= '0;
            sclk    <= 1'b0;
        end else if (load) begin
            bit_cnt <= cnt_t'($bits(word_t));
            sclk    <= 1'b0;
        end else if (busy) begin
            sclk <= ~sclk;
            if (sclk) begin
                bit_cnt <= bit_cnt - 1'b1;
            end
        end
    end

    // next bit appears as sclk falls
    always_ff @(posedge clock_33) begin
        if (load) begin
            shift_reg <= word;
        end else if (busy && sclk) begin
            shift_reg <= shift_reg << 1;
        end
    end

endmodule

// ==== design/display_executor.sv ====
module display_executor import pov_pkg::*; (
    input  logic      clock_33,
    input  logic      nrst,
    cmd_if.performer  cmd,
    output logic      sclk,
    output logic      sin,
    output logic      lat,
    output conf_t     conf,
    output rotation_t rotation,
    output logic      column_pulse,
    output logic      sync_pulse
);

    typedef enum logic [1:0] {
        EX_IDLE,
        EX_SHIFT,
        EX_LATCH,
        EX_ACK
    } ex_state_t;

    ex_state_t state;
    logic      start_conf, start_column;
    logic      conf_busy, column_busy;
    logic      conf_sclk, column_sclk;
    logic      conf_sin, column_sin;
    logic      shift_busy;

    assign start_conf   = (state == EX_IDLE) & cmd.req & (cmd.op == OP_CONFIG);
    assign start_column = (state == EX_IDLE) & cmd.req & (cmd.op == OP_COLUMN);

    driver_shifter #(.word_t(conf_t)) conf_shifter (
        .clock_33 (clock_33),
        .nrst     (nrst),
        .start    (start_conf),
        .word     (cmd.payload),
        .busy     (conf_busy),
        .sclk     (conf_sclk),
        .sin      (conf_sin)
    );

    driver_shifter #(.word_t(column_t)) column_shifter (
        .clock_33 (clock_33),
        .nrst     (nrst),
        .start    (start_column),
        .word     (cmd.payload[COLUMN_BITS-1:0]),
        .busy     (column_busy),
        .sclk     (column_sclk),
        .sin      (column_sin)
    );

    // idle shifter holds both lines low
    assign sclk       = conf_sclk | column_sclk;
    assign sin        = conf_sin | column_sin;
    assign shift_busy = conf_busy | column_busy;

    always_ff @(posedge clock_33 or negedge nrst) begin
        if (!nrst) begin
            state        <= EX_IDLE;
            cmd.ack      <= 1'b0;
            lat          <= 1'b0;
            conf         <= '0;
            rotation     <= '0;
            column_pulse <= 1'b0;
            sync_pulse   <= 1'b0;
        end else begin
            column_pulse <= 1'b0;
            sync_pulse   <= 1'b0;
            case (state)
                EX_IDLE: begin
                    if (cmd.req) begin
                        if (cmd.op == OP_ROTATION) begin
                            // no shifting, new sweep starts here
                            rotation   <= cmd.payload[ROTATION_BITS-1:0];
                            sync_pulse <= 1'b1;
                            cmd.ack    <= 1'b1;
                            state      <= EX_ACK;
                        end else begin
                            state <= EX_SHIFT;
                        end
                    end
                end
                EX_SHIFT: begin
                    if (!shift_busy) begin
                        lat   <= 1'b1;
                        state <= EX_LATCH;
                        if (cmd.op == OP_CONFIG) begin
                            conf <= cmd.payload;
                        end
                    end
                end
                EX_LATCH: begin
                    lat          <= 1'b0;
                    cmd.ack      <= 1'b1;
                    column_pulse <= (cmd.op == OP_COLUMN);
                    state        <= EX_ACK;
                end
                EX_ACK: begin
                    if (!cmd.req) begin
                        cmd.ack <= 1'b0;
                        state   <= EX_IDLE;
                    end
                end
                default: state <= EX_IDLE;
            endcase
        end
    end

endmodule

// ==== design/frame_status.sv ====
module frame_status import pov_pkg::*; (
    input  logic   clock_33,
    input  logic   nrst,
    input  logic   column_pulse,
    input  logic   sync_pulse,
    input  logic   bad_pulse,
    input  logic   overrun_pulse,
    output count_t column_count,
    output count_t bad_frames,
    output logic   overrun
);

    always_ff @(posedge clock_33 or negedge nrst) begin
        if (!nrst) begin
            column_count <= '0;
            bad_frames   <= '0;
            overrun      <= 1'b0;
        end else begin
            // columns since the last rotation sync
            if (sync_pulse) begin
                column_count <= '0;
            end else if (column_pulse) begin
                column_count <= column_count + 1'b1;
            end
            if (bad_pulse) begin
                bad_frames <= bad_frames + 1'b1;
            end
            // sticky until reset
            if (overrun_pulse) begin
                overrun <= 1'b1;
            end
        end
    end

endmodule

// ==== design/pov_display_core.sv ====
module pov_display_core import pov_pkg::*; (
    input  logic      clock_33,
    input  logic      nrst,
    input  logic      spi_clk,
    input  logic      spi_ss,
    input  logic      spi_mosi,
    output logic      sclk,
    output logic      sin,
    output logic      lat,
    output conf_t     conf,
    output rotation_t rotation,
    output count_t    column_count,
    output count_t    bad_frames,
    output logic      overrun,
    output logic      driver_ready
);

    logic                  frame_valid;
    logic [FRAME_BITS-1:0] frame_data;
    logic                  frame_take;
    logic                  overrun_pulse;
    logic                  bad_pulse;
    logic                  decoder_idle;
    logic                  column_pulse;
    logic                  sync_pulse;

    cmd_if cmd ();

    spi_frame_rx i_spi_frame_rx (
        .clock_33      (clock_33),
        .nrst          (nrst),
        .spi_clk       (spi_clk),
        .spi_ss        (spi_ss),
        .spi_mosi      (spi_mosi),
        .frame_take    (frame_take),
        .frame_valid   (frame_valid),
        .frame_data    (frame_data),
        .overrun_pulse (overrun_pulse)
    );

    command_decoder i_command_decoder (
        .clock_33    (clock_33),
        .nrst        (nrst),
        .frame_valid (frame_valid),
        .frame_data  (frame_data),
        .frame_take  (frame_take),
        .bad_pulse   (bad_pulse),
        .idle        (decoder_idle),
        .cmd         (cmd.issuer)
    );

    display_executor i_display_executor (
        .clock_33     (clock_33),
        .nrst         (nrst),
        .cmd          (cmd.performer),
        .sclk         (sclk),
        .sin          (sin),
        .lat          (lat),
        .conf         (conf),
        .rotation     (rotation),
        .column_pulse (column_pulse),
        .sync_pulse   (sync_pulse)
    );

    frame_status i_frame_status (
        .clock_33      (clock_33),
        .nrst          (nrst),
        .column_pulse  (column_pulse),
        .sync_pulse    (sync_pulse),
        .bad_pulse     (bad_pulse),
        .overrun_pulse (overrun_pulse),
        .column_count  (column_count),
        .bad_frames    (bad_frames),
        .overrun       (overrun)
    );

    // nothing pending, nothing in execution
    assign driver_ready = ~frame_valid & decoder_idle & ~cmd.ack;

endmodule

// ==== testbench/pov_display_chk.sv ====
module pov_display_chk import pov_pkg::*; (
    input logic     clock_33,
    input logic     nrst,
    input logic     sclk,
    input logic     sin,
    input logic     lat,
    input logic     req,
    input logic     ack,
    input opcode_t  op,
    input payload_t payload
);

    // number of assertion failures so far
    int fail_count = 0;

    // latch only with the serial clock low
    lat_with_sclk_low: assert property (@(posedge clock_33) disable iff (!nrst)
        !(lat && sclk))
        else begin
            fail_count++;
            $error("lat high while sclk high");
        end

    // data set up while sclk is low, held through the high phase
    sin_stable_on_sclk: assert property (@(posedge clock_33) disable iff (!nrst)
        sclk |-> $stable(sin))
        else begin
            fail_count++;
            $error("sin changed while sclk high");
        end

    cmd_stable_during_req: assert property (@(posedge clock_33) disable iff (!nrst)
        (req && $past(req)) |-> ($stable(op) && $stable(payload)))
        else begin
            fail_count++;
            $error("command changed while req high");
        end

    ack_follows_req: assert property (@(posedge clock_33) disable iff (!nrst)
        $rose(ack) |-> req)
        else begin
            fail_count++;
            $error("ack rose without req");
        end

endmodule

bind pov_display_core pov_display_chk i_pov_display_chk (
    .clock_33 (clock_33),
    .nrst     (nrst),
    .sclk     (sclk),
    .sin      (sin),
    .lat      (lat),
    .req      (cmd.req),
    .ack      (cmd.ack),
    .op       (cmd.op),
    .payload  (cmd.payload)
);

// ==== testbench/tb_pov_display_core.sv ====
module tb_pov_display_core import pov_pkg::*; ();

    localparam int SPI_HALF = 3;
    localparam int N_ENTRIES = 12;
    localparam int N_BURST = 3;
    localparam int TIMEOUT_CYCLES = 400 * (N_ENTRIES + N_BURST) + 1000;

    typedef enum {K_CONF, K_COLUMN, K_ROTATION, K_BAD, K_SHORT} kind_t;

    typedef struct {
        logic [OPCODE_BITS-1:0] op;
        payload_t               payload;
        kind_t                  kind;
        int                     nbits;
    } entry_t;

    logic      clock_33, nrst, spi_clk, spi_ss, spi_mosi;
    logic      sclk, sin, lat, overrun, driver_ready;
    conf_t     conf;
    rotation_t rotation;
    count_t    column_count, bad_frames;

    entry_t      stim [N_ENTRIES];
    logic [31:0] lcg_state;
    int          cycle_count = 0;
    int          error_count = 0;
    conf_t       exp_conf;
    rotation_t   exp_rotation;
    count_t      exp_columns, exp_bad;

    // driver chain capture
    logic [63:0] cap;
    int          cap_bits = 0;
    int          sclk_total = 0;
    logic [63:0] word_q [$];
    int          bits_q [$];

    pov_display_core i_pov_display_core (
        .clock_33 (clock_33), .nrst (nrst), .spi_clk (spi_clk), .spi_ss (spi_ss),
        .spi_mosi (spi_mosi), .sclk (sclk), .sin (sin), .lat (lat), .conf (conf),
        .rotation (rotation), .column_count (column_count), .bad_frames (bad_frames),
        .overrun (overrun), .driver_ready (driver_ready)
    );

    initial begin
        clock_33 = 1'b0;
        forever #50 clock_33 = ~clock_33;
    end

    always @(posedge clock_33) cycle_count <= cycle_count + 1;

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("timeout: the run hung waiting for the DUT");
        $display("TESTS FAILED");
        $fatal(1);
    end

    // sclk and lat are never high together
    always @(posedge sclk or posedge lat) begin
        if (lat) begin
            word_q.push_back(cap);
            bits_q.push_back(cap_bits);
            cap      = '0;
            cap_bits = 0;
        end else begin
            cap        = {cap[62:0], sin};
            cap_bits   = cap_bits + 1;
            sclk_total = sclk_total + 1;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic draw_payload(output payload_t p);
        lcg_state   = lcg_next(lcg_state);
        p[47:32]    = lcg_state[31:16];
        lcg_state   = lcg_next(lcg_state);
        p[31:0]     = lcg_state;
    endtask

    task automatic stop_on_error(input string line);
        error_count = error_count + 1;
        $display("%s", line);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    always @(negedge clock_33) begin
        if (i_pov_display_core.i_pov_display_chk.fail_count != 0)
            stop_on_error("an assertion on the serial bus or the handshake failed");
    end

    task automatic check_conf(input string name, input conf_t exp, input conf_t act);
        if (act !== exp)
            stop_on_error($sformatf("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act));
    endtask

    task automatic check_column(input string name, input column_t exp, input column_t act);
        if (act !== exp)
            stop_on_error($sformatf("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act));
    endtask

    task automatic check_rotation(input string name, input rotation_t exp, input rotation_t act);
        if (act !== exp)
            stop_on_error($sformatf("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act));
    endtask

    task automatic check_count(input string name, input count_t exp, input count_t act);
        if (act !== exp)
            stop_on_error($sformatf("[ERROR] %0t %s expected %0d actual %0d", $time, name, exp, act));
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
            stop_on_error($sformatf("[ERROR] %0t %s expected %b actual %b", $time, name, exp, act));
    endtask

    task automatic check_pulses(input string name, input int exp, input int act);
        if (act != exp)
            stop_on_error($sformatf("[ERROR] %0t %s expected %0d actual %0d", $time, name, exp, act));
    endtask

    task automatic check_state();
        check_conf("conf", exp_conf, conf);
        check_rotation("rotation", exp_rotation, rotation);
        check_count("column_count", exp_columns, column_count);
        check_count("bad_frames", exp_bad, bad_frames);
        check_flag("overrun", 1'b0, overrun);
        check_flag("driver_ready", 1'b1, driver_ready);
    endtask

    // msb first, data set while spi_clk is low
    task automatic send_frame(input logic [FRAME_BITS-1:0] frame, input int nbits);
        spi_ss = 1'b0;
        repeat (SPI_HALF) @(negedge clock_33);
        for (int i = 0; i < nbits; i++) begin
            spi_mosi = frame[FRAME_BITS-1-i];
            repeat (SPI_HALF) @(negedge clock_33);
            spi_clk = 1'b1;
            repeat (SPI_HALF) @(negedge clock_33);
            spi_clk = 1'b0;
        end
        repeat (SPI_HALF) @(negedge clock_33);
        spi_ss   = 1'b1;
        spi_mosi = 1'b0;
        // frame reaches the decoder within 4 cycles
        repeat (6) @(negedge clock_33);
    endtask

    task automatic wait_ready();
        while (!driver_ready) @(negedge clock_33);
    endtask

    task automatic build_stimulus();
        payload_t p;
        stim[0] = '{OP_CONFIG, 48'h1234_5678_9abc, K_CONF, FRAME_BITS};
        stim[1] = '{OP_COLUMN, 48'hffff_2aaa_aaaa, K_COLUMN, FRAME_BITS};
        draw_payload(p);
        stim[2] = '{OP_COLUMN, p, K_COLUMN, FRAME_BITS};
        draw_payload(p);
        stim[3] = '{OP_ROTATION, p, K_ROTATION, FRAME_BITS};
        draw_payload(p);
        stim[4] = '{OP_COLUMN, p, K_COLUMN, FRAME_BITS};
        draw_payload(p);
        stim[5] = '{8'h7f, p, K_BAD, FRAME_BITS};
        draw_payload(p);
        stim[6] = '{OP_COLUMN, p, K_SHORT, 40};
        draw_payload(p);
        stim[7] = '{OP_CONFIG, p, K_CONF, FRAME_BITS};
        draw_payload(p);
        stim[8] = '{OP_COLUMN, p, K_COLUMN, FRAME_BITS};
        stim[9] = '{OP_ROTATION, 48'h0000_0000_beef, K_ROTATION, FRAME_BITS};
        draw_payload(p);
        stim[10] = '{8'h00, p, K_BAD, FRAME_BITS};
        draw_payload(p);
        stim[11] = '{OP_COLUMN, p, K_COLUMN, FRAME_BITS};
    endtask

    task automatic apply_entry(input entry_t e);
        int          pulses_before;
        int          exp_pulses;
        int          exp_latches;
        logic [63:0] w;
        pulses_before = sclk_total;
        exp_pulses    = 0;
        exp_latches   = 0;
        send_frame({e.op, e.payload}, e.nbits);
        wait_ready();
        case (e.kind)
            K_CONF: begin
                exp_pulses  = CONF_BITS;
                exp_latches = 1;
            end
            K_COLUMN: begin
                exp_pulses  = COLUMN_BITS;
                exp_latches = 1;
            end
            K_ROTATION: begin
                exp_rotation = e.payload[ROTATION_BITS-1:0];
                exp_columns  = '0;
            end
            K_BAD: exp_bad = exp_bad + 1'b1;
            default: ;
        endcase
        check_pulses("sclk pulses", exp_pulses, sclk_total - pulses_before);
        check_pulses("lat pulses", exp_latches, word_q.size());
        if (exp_latches == 1) begin
            w = word_q.pop_front();
            check_pulses("captured bits", exp_pulses, bits_q.pop_front());
            if (e.kind == K_CONF) begin
                check_conf("captured conf word", e.payload, w[CONF_BITS-1:0]);
                exp_conf = e.payload;
            end else begin
                check_column("captured column word", e.payload[COLUMN_BITS-1:0],
                             w[COLUMN_BITS-1:0]);
                exp_columns = exp_columns + 1'b1;
            end
        end
        check_state();
    endtask

    // a column shifts in far less time than one frame takes to arrive,
    // so each command is done before the next frame lands and none is dropped
    task automatic run_back_to_back();
        payload_t    p [N_BURST];
        logic [63:0] w;
        int          pulses_before;
        pulses_before = sclk_total;
        for (int k = 0; k < N_BURST; k++) draw_payload(p[k]);
        for (int k = 0; k < N_BURST; k++) send_frame({OP_COLUMN, p[k]}, FRAME_BITS);
        wait_ready();
        check_pulses("sclk pulses", N_BURST * COLUMN_BITS, sclk_total - pulses_before);
        check_pulses("lat pulses", N_BURST, word_q.size());
        for (int k = 0; k < N_BURST; k++) begin
            w = word_q.pop_front();
            check_pulses("captured bits", COLUMN_BITS, bits_q.pop_front());
            check_column("captured column word", p[k][COLUMN_BITS-1:0], w[COLUMN_BITS-1:0]);
        end
        exp_columns = exp_columns + count_t'(N_BURST);
        check_state();
    endtask

    initial begin
        nrst         = 1'b0;
        spi_clk      = 1'b0;
        spi_ss       = 1'b1;
        spi_mosi     = 1'b0;
        cap          = '0;
        lcg_state    = 32'd89;
        exp_conf     = '0;
        exp_rotation = '0;
        exp_columns  = '0;
        exp_bad      = '0;
        build_stimulus();
        repeat (2) @(negedge clock_33);
        nrst = 1'b1;
        @(negedge clock_33);
        check_flag("sclk", 1'b0, sclk);
        check_flag("sin", 1'b0, sin);
        check_flag("lat", 1'b0, lat);
        check_state();
        for (int n = 0; n < N_ENTRIES; n++) apply_entry(stim[n]);
        run_back_to_back();
        if (error_count == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== sources.f ====
design/pov_pkg.sv
design/cmd_if.sv
design/spi_frame_rx.sv
design/command_decoder.sv
design/driver_shifter.sv
design/display_executor.sv
design/frame_status.sv
design/pov_display_core.sv
testbench/pov_display_chk.sv
testbench/tb_pov_display_core.sv

// ==== Bender.yml ====
package:
  name: pov_display

sources:
  - design/pov_pkg.sv
  - design/cmd_if.sv
  - design/spi_frame_rx.sv
  - design/command_decoder.sv
  - design/driver_shifter.sv
  - design/display_executor.sv
  - design/frame_status.sv
  - design/pov_display_core.sv
  - target: simulation
    files:
      - testbench/pov_display_chk.sv
      - testbench/tb_pov_display_core.sv
